// ==== memCtrl.f ====
design/memCtrlPkg.sv
design/memRequestArbiter.sv
design/memByteSequencer.sv
design/memWordAssembler.sv
design/memCtrl.sv
dv/tbClock.sv
dv/ramModel.sv
dv/memCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memCtrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module memCtrlTb -f memCtrl.f

out=$(./obj_dir/VmemCtrlTb)
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED"

// ==== dv/memCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrlTb;

    localparam int MAX_CYCLES = 2000;

    logic                            clk;
    logic                            rst;
    logic                            rdy = 1'b1;
    logic                            fetchEn;
    logic [memCtrlPkg::ADDR_W-1:0]   fetchAddr;
    logic                            fetchDone;
    logic [memCtrlPkg::DATA_W-1:0]   fetchInst;
    logic                            dataEn;
    logic                            dataIsStore;
    logic [memCtrlPkg::LEN_W-1:0]    dataLen;
    logic [memCtrlPkg::ADDR_W-1:0]   dataAddr;
    logic [memCtrlPkg::DATA_W-1:0]   dataWrite;
    logic                            dataDone;
    logic [memCtrlPkg::DATA_W-1:0]   dataRead;
    logic [memCtrlPkg::BYTE_W-1:0]   memRead;
    memCtrlPkg::memPort_t            memPort;
    logic                            busy;

    // expected RAM contents
    logic [7:0]  expMem [256];
    logic [31:0] rngState = 32'h2f2ef0ab;
    logic        stallMode = 1'b0;
    logic        prevBusy = 1'b0;
    int cycleCount = 0;
    int errorCount = 0;
    int lastErrors = 0;
    int testCount = 0;
    int failedTests = 0;
    int fetchesIssued = 0;
    int dataIssued = 0;
    int fetchDoneCount = 0;
    int dataDoneCount = 0;

    tbClock clkGen (
        .o_clk (clk)
    );

    memCtrl DUT (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (rdy),
        .i_fetchEn     (fetchEn),
        .i_fetchAddr   (fetchAddr),
        .o_fetchDone   (fetchDone),
        .o_fetchInst   (fetchInst),
        .i_dataEn      (dataEn),
        .i_dataIsStore (dataIsStore),
        .i_dataLen     (dataLen),
        .i_dataAddr    (dataAddr),
        .i_dataWrite   (dataWrite),
        .o_dataDone    (dataDone),
        .o_dataRead    (dataRead),
        .i_memRead     (memRead),
        .o_memPort     (memPort),
        .o_busy        (busy)
    );

    ramModel ram (
        .clk     (clk),
        .i_port  (memPort),
        .o_rdata (memRead)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ready is high three times out of four in stall mode
    always @(posedge clk) begin
        if (stallMode && !rst) begin
            rngState <= xorshift(rngState);
            rdy      <= (rngState[1:0] != 2'b00);
        end else begin
            rdy <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, a transfer never finished", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && fetchDone) begin
            fetchDoneCount++;
        end
        if (!rst && dataDone) begin
            dataDoneCount++;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errorCount++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount == lastErrors) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errorCount - lastErrors);
        end
        lastErrors = errorCount;
    endtask

    // little-endian word of len bytes, zero-extended
    function automatic logic [31:0] expWord(input logic [31:0] addr, input logic [2:0] len);
        logic [31:0] w;
        logic [7:0]  idx;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            idx = addr[7:0] + 8'(k);
            w[k*8 +: 8] = expMem[idx];
        end
        return w;
    endfunction

    // samples at the falling edge until the wanted done pulse
    task automatic waitDone(input logic wantFetch, output logic [31:0] word,
                            output int busyCycles);
        logic sawBusy;
        logic finished;
        sawBusy = 1'b0;
        finished = 1'b0;
        busyCycles = 0;
        word = '0;
        while (!finished) begin
            @(negedge clk);
            if (busy && !prevBusy) begin
                sawBusy = 1'b1;
            end
            if (sawBusy && busy) begin
                busyCycles++;
            end
            checkTrue(!sawBusy || busy, "o_busy fell before the done pulse");
            checkTrue(!(wantFetch ? dataDone : fetchDone), "done pulse came on the wrong port");
            if (wantFetch ? fetchDone : dataDone) begin
                checkTrue(sawBusy && busy, "done pulse without o_busy rising from low");
                word = wantFetch ? fetchInst : dataRead;
                finished = 1'b1;
            end
            prevBusy = busy;
        end
    endtask

    task automatic fetchXfer(input logic [31:0] addr);
        logic [31:0] word;
        int busyCycles;
        @(negedge clk);
        prevBusy = busy;
        @(posedge clk);
        fetchEn   <= 1'b1;
        fetchAddr <= addr;
        waitDone(1'b1, word, busyCycles);
        @(posedge clk);
        fetchEn <= 1'b0;
        fetchesIssued++;
        checkValue("o_fetchInst", word, expWord(addr, 3'd4));
        if (!stallMode) begin
            checkValue("o_busy cycles", busyCycles, 32'd6);
        end
    endtask

    task automatic dataXfer(input logic isStore, input logic [2:0] len,
                            input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] word;
        logic [7:0]  idx;
        int busyCycles;
        @(negedge clk);
        prevBusy = busy;
        @(posedge clk);
        dataEn      <= 1'b1;
        dataIsStore <= isStore;
        dataLen     <= len;
        dataAddr    <= addr;
        dataWrite   <= wdata;
        waitDone(1'b0, word, busyCycles);
        @(posedge clk);
        dataEn <= 1'b0;
        dataIssued++;
        if (!stallMode) begin
            checkValue("o_busy cycles", busyCycles, 32'(len) + 32'd2);
        end
        if (isStore) begin
            for (int k = 0; k < int'(len); k++) begin
                idx = addr[7:0] + 8'(k);
                expMem[idx] = wdata[k*8 +: 8];
            end
            // bytes past len must be untouched
            for (int k = 0; k < 4; k++) begin
                idx = addr[7:0] + 8'(k);
                checkValue("RAM byte", {24'b0, ram.mem[idx]}, {24'b0, expMem[idx]});
            end
        end else begin
            checkValue("o_dataRead", word, expWord(addr, len));
        end
    endtask

    task automatic priorityPair(input logic [31:0] fAddr, input logic [31:0] dAddr);
        logic [31:0] word;
        int busyCycles;
        @(negedge clk);
        prevBusy = busy;
        @(posedge clk);
        fetchEn     <= 1'b1;
        fetchAddr   <= fAddr;
        dataEn      <= 1'b1;
        dataIsStore <= 1'b0;
        dataLen     <= 3'd2;
        dataAddr    <= dAddr;
        waitDone(1'b0, word, busyCycles);
        @(posedge clk);
        dataEn <= 1'b0;
        checkValue("o_dataRead", word, expWord(dAddr, 3'd2));
        waitDone(1'b1, word, busyCycles);
        @(posedge clk);
        fetchEn <= 1'b0;
        checkValue("o_fetchInst", word, expWord(fAddr, 3'd4));
        fetchesIssued++;
        dataIssued++;
    endtask

    task automatic resetTest();
        @(negedge clk);
        checkValue("o_fetchDone", {31'b0, fetchDone}, 32'd0);
        checkValue("o_dataDone", {31'b0, dataDone}, 32'd0);
        checkValue("o_busy", {31'b0, busy}, 32'd0);
        checkValue("o_memPort.write", {31'b0, memPort.write}, 32'd0);
        checkValue("o_fetchInst", fetchInst, 32'd0);
        checkValue("o_dataRead", dataRead, 32'd0);
        reportTest("reset");
    endtask

    task automatic fetchTest();
        fetchXfer(32'h10);
        fetchXfer(32'h47);
        // wraps past the top of the RAM model
        fetchXfer(32'hfe);
        reportTest("fetch");
    endtask

    task automatic loadWidthTest();
        dataXfer(1'b0, 3'd1, 32'h21, '0);
        dataXfer(1'b0, 3'd2, 32'h33, '0);
        dataXfer(1'b0, 3'd4, 32'h45, '0);
        reportTest("load widths");
    endtask

    task automatic storeLoadTest();
        dataXfer(1'b1, 3'd1, 32'h61, 32'hdeadbeef);
        dataXfer(1'b0, 3'd4, 32'h61, '0);
        dataXfer(1'b1, 3'd2, 32'h73, 32'h1234abcd);
        dataXfer(1'b0, 3'd4, 32'h73, '0);
        dataXfer(1'b1, 3'd4, 32'h85, 32'hcafe0f0f);
        dataXfer(1'b0, 3'd4, 32'h85, '0);
        reportTest("store then load");
    endtask

    task automatic priorityTest();
        priorityPair(32'hb2, 32'hc7);
        reportTest("priority");
    endtask

    task automatic stallTest();
        @(negedge clk);
        stallMode = 1'b1;
        fetchXfer(32'h47);
        dataXfer(1'b0, 3'd1, 32'h21, '0);
        dataXfer(1'b0, 3'd2, 32'h33, '0);
        dataXfer(1'b0, 3'd4, 32'h45, '0);
        dataXfer(1'b1, 3'd2, 32'h95, 32'h5a5ac3d4);
        dataXfer(1'b0, 3'd4, 32'h95, '0);
        dataXfer(1'b1, 3'd4, 32'ha1, 32'h0badf00d);
        dataXfer(1'b0, 3'd4, 32'ha1, '0);
        priorityPair(32'hd3, 32'he9);
        @(negedge clk);
        stallMode = 1'b0;
        reportTest("random stall");
    endtask

    initial begin
        for (int a = 0; a < 256; a++) begin
            expMem[a] = 8'(a * 7 + 3);
        end
        rst         <= 1'b1;
        fetchEn     <= 1'b0;
        fetchAddr   <= '0;
        dataEn      <= 1'b0;
        dataIsStore <= 1'b0;
        dataLen     <= '0;
        dataAddr    <= '0;
        dataWrite   <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        fetchTest();
        loadWidthTest();
        storeLoadTest();
        priorityTest();
        stallTest();
        checkValue("o_fetchDone pulses", fetchDoneCount, fetchesIssued);
        checkValue("o_dataDone pulses", dataDoneCount, dataIssued);
        $display("summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ramModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramModel (
    input  wire                              clk,
    input  wire memCtrlPkg::memPort_t        i_port,
    output logic [memCtrlPkg::BYTE_W-1:0]    o_rdata
);

    // 256 bytes, the low address byte picks the location
    logic [memCtrlPkg::BYTE_W-1:0] mem [256];
    logic [7:0]                    index;

    assign index = i_port.addr[7:0];

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] <= 8'(a * 7 + 3);
        end
        o_rdata <= '0;
    end

    always @(posedge clk) begin
        if (i_port.write) begin
            mem[index] <= i_port.wdata;
        end
        // one cycle read latency, old data on a write to the same byte
        o_rdata <= mem[index];
    end

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic o_clk
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// ==== design/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_rdy,

    // instruction fetch
    input  wire                                i_fetchEn,
    input  wire [memCtrlPkg::ADDR_W-1:0]       i_fetchAddr,
    output logic                               o_fetchDone,
    output logic [memCtrlPkg::DATA_W-1:0]      o_fetchInst,

    // data port
    input  wire                                i_dataEn,
    input  wire                                i_dataIsStore,
    input  wire [memCtrlPkg::LEN_W-1:0]        i_dataLen,
    input  wire [memCtrlPkg::ADDR_W-1:0]       i_dataAddr,
    input  wire [memCtrlPkg::DATA_W-1:0]       i_dataWrite,
    output logic                               o_dataDone,
    output logic [memCtrlPkg::DATA_W-1:0]      o_dataRead,

    // RAM
    input  wire [memCtrlPkg::BYTE_W-1:0]       i_memRead,
    output memCtrlPkg::memPort_t               o_memPort,

    output logic                               o_busy
);

    memCtrlPkg::memReq_t  req;
    memCtrlPkg::byteTag_t tag;
    logic                 xferDone;

    memRequestArbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_fetchEn     (i_fetchEn),
        .i_fetchAddr   (i_fetchAddr),
        .i_dataEn      (i_dataEn),
        .i_dataIsStore (i_dataIsStore),
        .i_dataLen     (i_dataLen),
        .i_dataAddr    (i_dataAddr),
        .i_dataWrite   (i_dataWrite),
        .i_xferDone    (xferDone),
        .o_req         (req),
        .o_busy        (o_busy)
    );

    memByteSequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .i_rdy     (i_rdy),
        .i_req     (req),
        .o_memPort (o_memPort),
        .o_tag     (tag)
    );

    // op comes from the latched request, stable for the whole transfer
    memWordAssembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_tag       (tag),
        .i_memRead   (i_memRead),
        .i_op        (req.op),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRead  (o_dataRead),
        .o_xferDone  (xferDone)
    );

endmodule

`default_nettype wire

// ==== design/memWordAssembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWordAssembler (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_rdy,
    input  wire memCtrlPkg::byteTag_t          i_tag,
    input  wire [memCtrlPkg::BYTE_W-1:0]       i_memRead,
    input  wire memCtrlPkg::memOp_e            i_op,
    output logic                               o_fetchDone,
    output logic [memCtrlPkg::DATA_W-1:0]      o_fetchInst,
    output logic                               o_dataDone,
    output logic [memCtrlPkg::DATA_W-1:0]      o_dataRead,
    output logic                               o_xferDone
);

    logic [memCtrlPkg::DATA_W-1:0] wordQ;
    logic [memCtrlPkg::DATA_W-1:0] nextWord;
    logic                          finish;
    logic                          isFetch;

    // start from zero on the first byte, so short loads come out zero-extended
    always_comb begin
        nextWord = i_tag.first ? '0 : wordQ;
        if (!i_tag.isStore) begin
            nextWord[i_tag.index*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = i_memRead;
        end
        finish  = i_tag.valid & i_tag.last;
        isFetch = (i_op == memCtrlPkg::OP_FETCH);
    end

    always_ff @(posedge clk) begin
        if (i_rdy && i_tag.valid) begin
            wordQ <= nextWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_fetchDone <= 1'b0;
            o_dataDone  <= 1'b0;
            o_xferDone  <= 1'b0;
            o_fetchInst <= '0;
            o_dataRead  <= '0;
        end else begin
            // requester pulses last one cycle, even when the next cycle stalls
            o_fetchDone <= i_rdy & finish & isFetch;
            o_dataDone  <= i_rdy & finish & ~isFetch;
            if (i_rdy) begin
                // internal done holds through a stall until the arbiter takes it
                o_xferDone <= finish;
                if (finish && isFetch) begin
                    o_fetchInst <= nextWord;
                end
                if (finish && i_op == memCtrlPkg::OP_LOAD) begin
                    o_dataRead <= nextWord;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/memByteSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module memByteSequencer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_rdy,
    input  wire memCtrlPkg::memReq_t   i_req,
    output memCtrlPkg::memPort_t       o_memPort,
    output memCtrlPkg::byteTag_t       o_tag
);

    // latched transfer
    logic                              active;
    logic [memCtrlPkg::ADDR_W-1:0]     baseAddr;
    logic [memCtrlPkg::LEN_W-1:0]      xferLen;
    logic [memCtrlPkg::DATA_W-1:0]     xferData;
    logic                              xferStore;
    logic [memCtrlPkg::IDX_W-1:0]      byteIdx;

    // byte going out this cycle
    logic                              issue;
    logic [memCtrlPkg::ADDR_W-1:0]     curBase;
    logic [memCtrlPkg::LEN_W-1:0]      curLen;
    logic [memCtrlPkg::DATA_W-1:0]     curData;
    logic                              curStore;
    logic [memCtrlPkg::IDX_W-1:0]      curIdx;
    logic [memCtrlPkg::LEN_W-1:0]      curCount;
    logic [memCtrlPkg::ADDR_W-1:0]     addrOffset;
    logic                              curLast;

    memCtrlPkg::memPort_t curPort;
    memCtrlPkg::memPort_t lastPort;
    memCtrlPkg::byteTag_t tagQ;

    // byte 0 leaves in the acceptance cycle, straight from the request
    always_comb begin
        if (i_req.valid) begin
            curBase  = i_req.addr;
            curLen   = i_req.len;
            curData  = i_req.wdata;
            curStore = (i_req.op == memCtrlPkg::OP_STORE);
            curIdx   = '0;
        end else begin
            curBase  = baseAddr;
            curLen   = xferLen;
            curData  = xferData;
            curStore = xferStore;
            curIdx   = byteIdx;
        end
        issue      = i_req.valid | active;
        curCount   = {{(memCtrlPkg::LEN_W - memCtrlPkg::IDX_W){1'b0}}, curIdx} + 1'b1;
        curLast    = (curCount == curLen);
        addrOffset = {{(memCtrlPkg::ADDR_W - memCtrlPkg::IDX_W){1'b0}}, curIdx};
    end

    always_comb begin
        curPort = '0;
        if (issue) begin
            curPort.write = curStore;
            curPort.addr  = curBase + addrOffset;
            if (curStore) begin
                curPort.wdata = curData[curIdx*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            byteIdx  <= '0;
            lastPort <= '0;
            tagQ     <= '0;
        end else if (i_rdy) begin
            lastPort     <= curPort;
            tagQ.valid   <= issue;
            tagQ.index   <= curIdx;
            tagQ.first   <= (curIdx == '0);
            tagQ.last    <= curLast;
            tagQ.isStore <= curStore;
            if (issue) begin
                active  <= ~curLast;
                byteIdx <= curIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rdy && i_req.valid) begin
            baseAddr  <= i_req.addr;
            xferLen   <= i_req.len;
            xferData  <= i_req.wdata;
            xferStore <= (i_req.op == memCtrlPkg::OP_STORE);
        end
    end

    // a stalled cycle repeats the last ready byte, so RAM data keeps matching the tag
    assign o_memPort = i_rdy ? curPort : lastPort;
    assign o_tag     = tagQ;

endmodule

`default_nettype wire

// ==== design/memRequestArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module memRequestArbiter (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_rdy,
    input  wire                                i_fetchEn,
    input  wire [memCtrlPkg::ADDR_W-1:0]       i_fetchAddr,
    input  wire                                i_dataEn,
    input  wire                                i_dataIsStore,
    input  wire [memCtrlPkg::LEN_W-1:0]        i_dataLen,
    input  wire [memCtrlPkg::ADDR_W-1:0]       i_dataAddr,
    input  wire [memCtrlPkg::DATA_W-1:0]       i_dataWrite,
    input  wire                                i_xferDone,
    output memCtrlPkg::memReq_t                o_req,
    output logic                               o_busy
);

    memCtrlPkg::arbState_e stateQ;
    memCtrlPkg::memReq_t   reqQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            stateQ     <= memCtrlPkg::ST_IDLE;
            reqQ.valid <= 1'b0;
        end else if (i_rdy) begin
            reqQ.valid <= 1'b0;
            case (stateQ)
                memCtrlPkg::ST_IDLE: begin
                    // data port goes ahead of fetch
                    if (i_dataEn) begin
                        reqQ.op    <= i_dataIsStore ? memCtrlPkg::OP_STORE
                                                    : memCtrlPkg::OP_LOAD;
                        reqQ.addr  <= i_dataAddr;
                        reqQ.len   <= i_dataLen;
                        reqQ.wdata <= i_dataWrite;
                        reqQ.valid <= 1'b1;
                        stateQ     <= memCtrlPkg::ST_BUSY;
                    end else if (i_fetchEn) begin
                        reqQ.op    <= memCtrlPkg::OP_FETCH;
                        reqQ.addr  <= i_fetchAddr;
                        reqQ.len   <= memCtrlPkg::FETCH_LEN;
                        reqQ.wdata <= '0;
                        reqQ.valid <= 1'b1;
                        stateQ     <= memCtrlPkg::ST_BUSY;
                    end
                end
                memCtrlPkg::ST_BUSY: begin
                    if (i_xferDone) begin
                        stateQ <= memCtrlPkg::ST_FINISH;
                    end
                end
                memCtrlPkg::ST_FINISH: begin
                    // one spare cycle so the finished requester can drop its enable
                    stateQ <= memCtrlPkg::ST_IDLE;
                end
                default: begin
                    stateQ <= memCtrlPkg::ST_IDLE;
                end
            endcase
        end
    end

    // op stays put for the whole transfer, the assembler relies on it
    assign o_req  = reqQ;
    assign o_busy = (stateQ == memCtrlPkg::ST_BUSY);

endmodule

`default_nettype wire

// ==== design/memCtrlPkg.sv ====
`default_nettype none

package memCtrlPkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int LEN_W  = 3;

    // byte index within a word
    localparam int IDX_W = 2;

    // fetches always move a whole word
    localparam logic [LEN_W-1:0] FETCH_LEN = 3'd4;

    typedef enum logic [1:0] {
        OP_FETCH,
        OP_LOAD,
        OP_STORE
    } memOp_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_FINISH
    } arbState_e;

    // accepted request, valid for one ready cycle
    typedef struct packed {
        memOp_e              op;
        logic [ADDR_W-1:0]   addr;
        logic [LEN_W-1:0]    len;
        logic [DATA_W-1:0]   wdata;
        logic                valid;
    } memReq_t;

    // byte-wide RAM port
    typedef struct packed {
        logic                write;
        logic [ADDR_W-1:0]   addr;
        logic [BYTE_W-1:0]   wdata;
    } memPort_t;

    // one issued byte, lined up with its read data
    typedef struct packed {
        logic                valid;
        logic [IDX_W-1:0]    index;
        logic                first;
        logic                last;
        logic                isStore;
    } byteTag_t;

endpackage

`default_nettype wire
